// File: build.f
logic/board_pkg.sv
logic/tick_gen.sv
logic/lab_core.sv
logic/seg_static_latch.sv
logic/i2s_tx.sv
logic/board_top.sv
sim/board_checker.sv
sim/board_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module board_tb -Mdir "$build_dir" -o board_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile step failed"
    exit 1
fi

"./$build_dir/board_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$log"; then
    exit 1
fi

if ! grep -q "Verification passed" "$log"; then
    echo "No result line found in $log"
    exit 1
fi

exit 0

// File: sim/board_tb.sv
`timescale 1ns/1ps

module board_tb
    import board_pkg::*;
();

    localparam int clk_ns      = 10;
    localparam int settle      = 8;     // Cycles for the static latch to catch up
    localparam int max_periods = 3;
    localparam int rounds      = 3;
    localparam int lr_wait     = 600;   // Longer than one lrclk period
    localparam int bit_wait    = 320;   // 17 bclk periods plus slack
    localparam int run_cycles  = 8 + 2 * (max_periods * tick_div + settle) + 6 * settle
                                 + rounds * (max_periods * tick_div + lr_wait + bit_wait)
                                 + 2000;

    logic                 clk;
    logic                 rst;
    logic [w_key - 1:0]   key_n;
    logic [w_sw - 1:0]    sw;
    logic [6:0]           hex0, hex1, hex2, hex3, hex4, hex5;
    logic [6:0]           hex_arr [w_digit];
    logic [w_led - 1:0]   ledr;
    logic                 i2s_mclk, i2s_bclk, i2s_lrclk, i2s_sdata;

    int unsigned          m_div;        // Model of the tick divider
    logic                 m_tick;
    logic [w_count - 1:0] m_counter;
    int                   checks = 0;
    int                   errors = 0;
    int                   test_base = 0;

    board_top uut
    (
        .clk       (clk),
        .rst       (rst),
        .key_n     (key_n),
        .sw        (sw),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5),
        .ledr      (ledr),
        .i2s_mclk  (i2s_mclk),
        .i2s_bclk  (i2s_bclk),
        .i2s_lrclk (i2s_lrclk),
        .i2s_sdata (i2s_sdata)
    );

    bind board_top board_checker u_checker
    (
        .clk   (clk),
        .rst   (rst),
        .digit (digit),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .hex4  (hex4),
        .hex5  (hex5),
        .bclk  (i2s_bclk),
        .sdata (i2s_sdata)
    );

    assign hex_arr[0] = hex0;
    assign hex_arr[1] = hex1;
    assign hex_arr[2] = hex2;
    assign hex_arr[3] = hex3;
    assign hex_arr[4] = hex4;
    assign hex_arr[5] = hex5;

    initial clk = 1'b0;
    always #(clk_ns / 2) clk = ~clk;

    //--------------------------------------------------
    // Reference model

    assign m_tick = (m_div == tick_div - 1);

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            m_div     <= 0;
            m_counter <= '0;
        end
        else
        begin
            m_div <= (m_div == tick_div - 1) ? 0 : m_div + 1;
            if (!key_n[0])
                m_counter <= '0;                // Key 0 clears first
            else if (m_tick && sw[0])
                m_counter <= m_counter + 1'b1;
        end
    end

    // Lit segments, gfedcba with a on bit 0
    function automatic logic [6:0] seg_pattern(input logic [3:0] nib);
        logic [6:0] pat;
        case (nib)
            4'h0: pat = 7'h3f;
            4'h1: pat = 7'h06;
            4'h2: pat = 7'h5b;
            4'h3: pat = 7'h4f;
            4'h4: pat = 7'h66;
            4'h5: pat = 7'h6d;
            4'h6: pat = 7'h7d;
            4'h7: pat = 7'h07;
            4'h8: pat = 7'h7f;
            4'h9: pat = 7'h6f;
            4'ha: pat = 7'h77;
            4'hb: pat = 7'h7c;
            4'hc: pat = 7'h39;
            4'hd: pat = 7'h5e;
            4'he: pat = 7'h79;
            default: pat = 7'h71;
        endcase
        return pat;
    endfunction

    //--------------------------------------------------
    // Helpers

    task automatic wait_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;                                 // Drive and sample after the edge
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            $display("ERR %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_hex_digits();
        for (int k = 0; k < w_digit; k++)
            check_value($sformatf("hex%0d", k), hex_arr[k],
                        7'(~seg_pattern(m_counter[4 * k +: 4])));
    endtask

    task automatic run_counter(input int periods);
        sw[0] = 1'b1;
        wait_cycles(periods * tick_div);        // Whole tick periods
        sw[0] = 1'b0;
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == test_base)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d error(s)", num, name, errors - test_base);
        test_base = errors;
    endtask

    // Left word after a falling lrclk, first bit slot skipped
    task automatic capture_i2s_word(output logic [15:0] word, output bit ok);
        logic lr_prev;
        logic bclk_prev;
        int   bits;
        word    = '0;
        ok      = 1'b0;
        lr_prev = i2s_lrclk;
        for (int n = 0; n < lr_wait && !ok; n++)
        begin
            wait_cycles(1);
            if (lr_prev && !i2s_lrclk)
                ok = 1'b1;
            lr_prev = i2s_lrclk;
        end
        if (ok)
        begin
            bits      = 0;
            bclk_prev = i2s_bclk;
            for (int n = 0; n < bit_wait && bits < 17; n++)
            begin
                wait_cycles(1);
                if (!bclk_prev && i2s_bclk)
                begin
                    if (bits > 0)
                        word = {word[14:0], i2s_sdata};
                    bits++;
                end
                bclk_prev = i2s_bclk;
            end
            ok = (bits == 17);
        end
    endtask

    //--------------------------------------------------
    // Test sequence

    initial
    begin
        int unsigned seed_ret;
        logic [3:0]  keys;
        logic [15:0] word;
        bit          ok;
        seed_ret = $urandom(95);
        rst   = 1'b1;
        key_n = '1;
        sw    = '0;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;

        for (int k = 0; k < w_digit; k++)
            check_value($sformatf("hex%0d", k), hex_arr[k], 7'h7f);
        check_value("ledr", ledr, 0);
        check_value("i2s_mclk", i2s_mclk, 0);
        check_value("i2s_bclk", i2s_bclk, 0);
        check_value("i2s_lrclk", i2s_lrclk, 0);
        check_value("i2s_sdata", i2s_sdata, 0);
        report_test(1, "reset");

        run_counter(1 + $urandom % max_periods);
        wait_cycles(settle);
        check_hex_digits();
        report_test(2, "counting");

        sw[w_sw - 1:w_sw - w_digit] = 6'($urandom);
        wait_cycles(settle);
        check_value("ledr[9:4]", ledr[w_led - 1:w_led - w_digit], sw[w_sw - 1:w_sw - w_digit]);
        check_hex_digits();
        report_test(3, "decimal points");

        key_n[0] = 1'b0;
        wait_cycles(1);
        key_n[0] = 1'b1;
        wait_cycles(settle);
        for (int k = 0; k < w_digit; k++)
            check_value($sformatf("hex%0d", k), hex_arr[k], 7'(~seg_pattern(4'h0)));
        keys  = 4'($urandom);
        key_n = keys;
        wait_cycles(2);
        check_value("ledr[3:0]", ledr[3:0], 4'(~keys));
        key_n = '1;
        wait_cycles(2);
        check_value("ledr[3:0]", ledr[3:0], 0);
        report_test(4, "clear and keys");

        for (int r = 0; r < rounds; r++)
        begin
            run_counter(1 + $urandom % max_periods);
            capture_i2s_word(word, ok);
            checks++;
            assert (ok)
            else
            begin
                $display("No complete I2S frame seen in audio round %0d", r);
                errors++;
            end
            if (ok)
                check_value("i2s_sdata word", word, m_counter[15:0]);
        end
        report_test(5, "audio");

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        #(run_cycles * clk_ns);
        $display("Watchdog expired after %0d cycles, the tests did not finish", run_cycles);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: sim/board_checker.sv
`timescale 1ns/1ps

module board_checker
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [w_digit - 1:0] digit,
    input  logic [6:0]           hex0,
    input  logic [6:0]           hex1,
    input  logic [6:0]           hex2,
    input  logic [6:0]           hex3,
    input  logic [6:0]           hex4,
    input  logic [6:0]           hex5,
    input  logic                 bclk,
    input  logic                 sdata
);

    logic [7 * w_digit - 1:0] hex_bus;
    logic [7:0]               bclk_hist;    // Last eight sampled bclk levels

    assign hex_bus = {hex5, hex4, hex3, hex2, hex1, hex0};

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bclk_hist <= '0;
        else
            bclk_hist <= {bclk_hist[6:0], bclk};
    end

    //--------------------------------------------------
    // Static display follows the scan

    for (genvar k = 0; k < w_digit; k++)
    begin : g_hex
        hex_follows_select: assert property (@(posedge clk) disable iff (rst)
            $changed(hex_bus[7 * k +: 7]) |-> $past(digit[k]))
        else $error("hex%0d changed without its digit select", k);
    end

    //--------------------------------------------------
    // I2S bit clock and data

    bclk_half_period: assert property (@(posedge clk) disable iff (rst)
        $changed(bclk) |-> (bclk_hist == 8'h00 || bclk_hist == 8'hff))
    else $error("bclk toggled sooner than 8 clocks after its last edge");

    sdata_held_high: assert property (@(posedge clk) disable iff (rst)
        (bclk && $past(bclk)) |-> $stable(sdata))
    else $error("sdata moved while bclk was high");

endmodule

// File: logic/board_top.sv
`timescale 1ns/1ps

module board_top
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [w_key - 1:0]   key_n,
    input  logic [w_sw - 1:0]    sw,
    output logic [6:0]           hex0,
    output logic [6:0]           hex1,
    output logic [6:0]           hex2,
    output logic [6:0]           hex3,
    output logic [6:0]           hex4,
    output logic [6:0]           hex5,
    output logic [w_led - 1:0]   ledr,
    output logic                 i2s_mclk,
    output logic                 i2s_bclk,
    output logic                 i2s_lrclk,
    output logic                 i2s_sdata
);

    logic [w_key - 1:0]           key;
    logic                         tick;
    seg_word_u                    seg;
    logic [w_digit - 1:0]         digit;
    logic [w_led - w_digit - 1:0] led;
    logic [w_digit - 1:0]         dp;
    logic [w_sample - 1:0]        sample;

    assign key = ~key_n;                    // Board keys are active low

    //--------------------------------------------------

    tick_gen u_tick_gen
    (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick)
    );

    lab_core u_lab_core
    (
        .clk    (clk),
        .rst    (rst),
        .tick   (tick),
        .key    (key),
        .sw     (sw),
        .seg    (seg),
        .digit  (digit),
        .led    (led),
        .sample (sample)
    );

    seg_static_latch u_seg_latch
    (
        .clk    (clk),
        .rst    (rst),
        .seg    (seg),
        .digit  (digit),
        .hex0   (hex0),
        .hex1   (hex1),
        .hex2   (hex2),
        .hex3   (hex3),
        .hex4   (hex4),
        .hex5   (hex5),
        .dp     (dp)
    );

    i2s_tx u_i2s_tx
    (
        .clk    (clk),
        .rst    (rst),
        .sample (sample),
        .mclk   (i2s_mclk),
        .bclk   (i2s_bclk),
        .lrclk  (i2s_lrclk),
        .sdata  (i2s_sdata)
    );

    assign ledr = {dp, led};                // dp lamps on the upper LEDs

endmodule

// File: logic/i2s_tx.sv
`timescale 1ns/1ps

module i2s_tx
    import board_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [w_sample - 1:0] sample,
    output logic                  mclk,
    output logic                  bclk,
    output logic                  lrclk,
    output logic                  sdata
);

    logic [8:0]            phase;           // 256 clocks per channel
    logic [w_sample - 1:0] word;            // Sample held for both channels
    logic [w_sample - 1:0] shift;
    logic                  bclk_fall;
    logic                  lr_change;

    //--------------------------------------------------
    // Clock generation

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            phase <= '0;
        else
            phase <= phase + 1'b1;
    end

    assign mclk  = phase[1];
    assign bclk  = phase[3];                // 16 clocks per bit
    assign lrclk = phase[8];                // Low for left

    assign bclk_fall = (phase[3:0] == 4'hf);    // Next edge drops bclk
    assign lr_change = (phase[7:0] == 8'hff);   // Next edge flips lrclk

    //--------------------------------------------------
    // Serializer

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word  <= '0;
            shift <= '0;
            sdata <= 1'b0;
        end
        else if (bclk_fall)
        begin
            sdata <= shift[w_sample - 1];   // LSB of the last word spills into slot 0
            if (lr_change && lrclk)
            begin
                word  <= sample;            // Capture as lrclk falls
                shift <= sample;
            end
            else if (lr_change)
                shift <= word;              // Right channel repeats the word
            else
                shift <= shift << 1;
        end
    end

endmodule

// File: logic/seg_static_latch.sv
`timescale 1ns/1ps

module seg_static_latch
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  seg_word_u            seg,
    input  logic [w_digit - 1:0] digit,
    output logic [6:0]           hex0,
    output logic [6:0]           hex1,
    output logic [6:0]           hex2,
    output logic [6:0]           hex3,
    output logic [6:0]           hex4,
    output logic [6:0]           hex5,
    output logic [w_digit - 1:0] dp
);

    logic [6:0] gfedcba_n;                  // Active-low, a on bit 0
    logic [6:0] hex_r [w_digit];

    assign gfedcba_n = ~{seg.fld.g, seg.fld.f, seg.fld.e, seg.fld.d,
                         seg.fld.c, seg.fld.b, seg.fld.a};

    // Each digit holds its last scanned value
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hex_r <= '{default: '1};        // All segments dark
            dp    <= '0;
        end
        else
        begin
            for (int i = 0; i < w_digit; i++)
            begin
                if (digit[i])
                begin
                    hex_r[i] <= gfedcba_n;
                    dp[i]    <= seg.fld.h;
                end
            end
        end
    end

    assign hex0 = hex_r[0];
    assign hex1 = hex_r[1];
    assign hex2 = hex_r[2];
    assign hex3 = hex_r[3];
    assign hex4 = hex_r[4];
    assign hex5 = hex_r[5];

endmodule

// File: logic/lab_core.sv
`timescale 1ns/1ps

module lab_core
    import board_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         tick,
    input  logic [w_key - 1:0]           key,
    input  logic [w_sw - 1:0]            sw,
    output seg_word_u                    seg,
    output logic [w_digit - 1:0]         digit,
    output logic [w_led - w_digit - 1:0] led,
    output logic [w_sample - 1:0]        sample
);

    logic [w_count - 1:0]         counter;
    logic [$clog2(w_digit) - 1:0] pos;      // Scan position
    seg_word_u                    seg_next;

    //--------------------------------------------------
    // Hex counter

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            counter <= '0;
        else if (key[0])
            counter <= '0;                  // Clear wins over counting
        else if (tick && sw[0])
            counter <= counter + 1'b1;
    end

    assign sample = counter[w_sample - 1:0];

    //--------------------------------------------------
    // Digit scanner

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            pos <= '0;
        else if (pos == w_digit - 1)
            pos <= '0;
        else
            pos <= pos + 1'b1;
    end

    always_comb
    begin
        seg_next.raw   = hex_to_seg(counter[4 * pos +: 4]);
        seg_next.fld.h = sw[w_sw - w_digit + pos];  // Upper switches light the dps
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            seg   <= '0;
            digit <= '0;
            led   <= '0;
        end
        else
        begin
            seg   <= seg_next;              // Payload travels with its select
            digit <= w_digit'(1) << pos;    // One-hot select
            led   <= key;
        end
    end

endmodule

// File: logic/tick_gen.sv
`timescale 1ns/1ps

module tick_gen
    import board_pkg::*;
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    logic [$clog2(tick_div) - 1:0] count;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            count <= '0;
        else if (count == tick_div - 1)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    assign tick = (count == tick_div - 1);  // One-cycle enable at the wrap

endmodule

// File: logic/board_pkg.sv
package board_pkg;

    //--------------------------------------------------
    // Board geometry

    localparam int w_key    = 4;
    localparam int w_sw     = 10;
    localparam int w_digit  = 6;
    localparam int w_led    = 10;   // Upper w_digit LEDs serve as dp lamps
    localparam int w_count  = 24;   // Four bits per digit
    localparam int w_sample = 16;
    localparam int tick_div = 1000; // Clocks per slow tick

    //--------------------------------------------------
    // Seven-segment word, abcdefgh with a on the MSB

    typedef struct packed
    {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic h;                    // Decimal point
    } seg_fields_t;

    typedef union packed
    {
        logic [7:0]  raw;
        seg_fields_t fld;
    } seg_word_u;

    // Positive logic, h always cleared
    function automatic logic [7:0] hex_to_seg(input logic [3:0] nibble);
        logic [7:0] code;
        case (nibble)
            4'h0: code = 8'b1111_1100;
            4'h1: code = 8'b0110_0000;
            4'h2: code = 8'b1101_1010;
            4'h3: code = 8'b1111_0010;
            4'h4: code = 8'b0110_0110;
            4'h5: code = 8'b1011_0110;
            4'h6: code = 8'b1011_1110;
            4'h7: code = 8'b1110_0000;
            4'h8: code = 8'b1111_1110;
            4'h9: code = 8'b1111_0110;
            4'ha: code = 8'b1110_1110;
            4'hb: code = 8'b0011_1110;
            4'hc: code = 8'b1001_1100;
            4'hd: code = 8'b0111_1010;
            4'he: code = 8'b1001_1110;
            default: code = 8'b1000_1110;
        endcase
        return code;
    endfunction

endpackage
